//--- logic/oled_pkg.sv
/*
 * oled display package
 * bus byte type, panel address, ssd1306 control bytes
 * and command opcodes shared by the display subsystem
 */

package oled_pkg;

	// one byte on the i2c link and in the frame buffer
	typedef logic [7:0] bus_byte_t;

	// 7-bit panel address, sent as 0x78 with the write bit
	localparam logic [6:0] OLED_I2C_ADDR = 7'h3c;

	// ------------------------------------------------------------------
	// control bytes preceding commands or data
	// ------------------------------------------------------------------
	localparam bus_byte_t CTRL_CMD_SINGLE  = 8'h80;
	localparam bus_byte_t CTRL_CMD_STREAM  = 8'h00;
	localparam bus_byte_t CTRL_DATA_STREAM = 8'h40;

	// ------------------------------------------------------------------
	// command opcodes
	// ------------------------------------------------------------------
	localparam bus_byte_t CMD_ENTIRE_ON     = 8'ha5;
	localparam bus_byte_t CMD_RESUME_RAM    = 8'ha4;
	localparam bus_byte_t CMD_DISPLAY_OFF   = 8'hae;
	localparam bus_byte_t CMD_DISPLAY_ON    = 8'haf;
	localparam bus_byte_t CMD_CLOCK_DIV     = 8'hd5;
	localparam bus_byte_t CMD_PRECHARGE     = 8'hd9;
	localparam bus_byte_t CMD_MULTIPLEX     = 8'ha8;
	localparam bus_byte_t CMD_ADDR_MODE     = 8'h20;
	localparam bus_byte_t CMD_SEG_REMAP     = 8'ha0;
	localparam bus_byte_t CMD_COM_SCAN      = 8'hc0;
	localparam bus_byte_t CMD_START_LINE    = 8'h40;
	localparam bus_byte_t CMD_DISPLAY_OFFS  = 8'hd3;
	localparam bus_byte_t CMD_CONTRAST      = 8'h81;
	localparam bus_byte_t CMD_NORMAL        = 8'ha6;
	localparam bus_byte_t CMD_CHARGE_PUMP   = 8'h8d;
	localparam bus_byte_t CMD_COL_ADDR      = 8'h21;
	localparam bus_byte_t CMD_PAGE_ADDR     = 8'h22;

	// sequence lengths in bytes, control bytes included
	localparam int INIT_BYTES   = 37;
	localparam int WINDOW_BYTES = 8;

endpackage

//--- logic/serial_bus_if.sv
/*
 * byte bus between the display controller and the i2c writer
 * controller offers bytes, writer takes them and reports idle
 */

`timescale 1ns/1ps

interface serial_bus_if;

	// high while the controller offers a byte
	logic enable;
	// offered byte, held until next_word
	oled_pkg::bus_byte_t data;
	// one-cycle pulse when the writer has taken data
	logic next_word;
	// writer idle, no transfer open
	logic ready;

	// controller side
	modport ctrl (
		output enable,
		output data,
		input  next_word,
		input  ready
	);

	// i2c writer side
	modport phy (
		input  enable,
		input  data,
		output next_word,
		output ready
	);

endinterface

//--- logic/frame_buffer.sv
/*
 * page-organised frame buffer
 * one byte per column and page, eight vertical pixels each
 * host write port, registered read port for the controller
 */

`timescale 1ns/1ps

module frame_buffer #(
	parameter int SCREEN_WIDTH = 128,
	parameter int SCREEN_HEIGHT = 64,
	localparam int PAGES = SCREEN_HEIGHT / 8,
	localparam int COL_BITS = (SCREEN_WIDTH > 1) ? $clog2(SCREEN_WIDTH) : 1,
	localparam int PAGE_BITS = (PAGES > 1) ? $clog2(PAGES) : 1
) (
	input  logic in_clk,

	// host side
	input  logic wr,
	input  logic [COL_BITS-1:0] wr_col,
	input  logic [PAGE_BITS-1:0] wr_page,
	input  oled_pkg::bus_byte_t wr_data,

	// controller side
	input  logic [COL_BITS-1:0] rd_col,
	input  logic [PAGE_BITS-1:0] rd_page,
	output oled_pkg::bus_byte_t rd_data
);

	localparam int DEPTH = SCREEN_WIDTH * PAGES;
	localparam int ADDR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	// page-major layout, column within page
	oled_pkg::bus_byte_t mem [DEPTH];

	logic [ADDR_BITS-1:0] wr_addr;
	logic [ADDR_BITS-1:0] rd_addr;

	assign wr_addr = ADDR_BITS'(int'(wr_page) * SCREEN_WIDTH + int'(wr_col));
	assign rd_addr = ADDR_BITS'(int'(rd_page) * SCREEN_WIDTH + int'(rd_col));

	// host write
	always_ff @(posedge in_clk) begin
		if (wr) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// one cycle read latency
	always_ff @(posedge in_clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

//--- logic/oled_serial.sv
/*
 * ssd1306 display controller
 * waits after reset, sends the init sequence, then per update
 * sends the address window and streams the frame buffer
 * page by page, each sequence as one i2c transaction
 */

`timescale 1ns/1ps

module oled_serial #(
	parameter int SCREEN_WIDTH = 128,
	parameter int SCREEN_HEIGHT = 64,
	parameter int WAIT_RESET = 1_000_000,
	parameter int WAIT_UPDATE = 2_500_000,
	localparam int PAGES = SCREEN_HEIGHT / 8,
	localparam int COL_BITS = (SCREEN_WIDTH > 1) ? $clog2(SCREEN_WIDTH) : 1,
	localparam int PAGE_BITS = (PAGES > 1) ? $clog2(PAGES) : 1
) (
	input  logic in_clk,
	input  logic in_rst,
	input  logic update,
	output logic [COL_BITS-1:0] rd_col,
	output logic [PAGE_BITS-1:0] rd_page,
	input  oled_pkg::bus_byte_t rd_data,
	serial_bus_if.ctrl bus
);

	// ------------------------------------------------------------------
	// command tables
	// ------------------------------------------------------------------
	localparam int INIT_IDX_BITS = $clog2(oled_pkg::INIT_BYTES);
	localparam int WIN_IDX_BITS = $clog2(oled_pkg::WINDOW_BYTES);

	// init sequence, 37 bytes
	localparam oled_pkg::bus_byte_t [0:oled_pkg::INIT_BYTES-1] INIT_TABLE = {
		// all pixels on, then off
		oled_pkg::CTRL_CMD_SINGLE, oled_pkg::CMD_ENTIRE_ON,
		oled_pkg::CTRL_CMD_SINGLE, oled_pkg::CMD_DISPLAY_OFF,
		// oscillator 15, divide by 1
		oled_pkg::CTRL_CMD_STREAM, oled_pkg::CMD_CLOCK_DIV, 8'hf0,
		// precharge phases 2 and 2
		oled_pkg::CTRL_CMD_STREAM, oled_pkg::CMD_PRECHARGE, 8'h22,
		// multiplex ratio follows panel height
		oled_pkg::CTRL_CMD_STREAM, oled_pkg::CMD_MULTIPLEX, 8'(SCREEN_HEIGHT - 1),
		// horizontal addressing
		oled_pkg::CTRL_CMD_STREAM, oled_pkg::CMD_ADDR_MODE, 8'h00,
		// mirrored columns and rows
		oled_pkg::CTRL_CMD_SINGLE, oled_pkg::CMD_SEG_REMAP | 8'h01,
		oled_pkg::CTRL_CMD_SINGLE, oled_pkg::CMD_COM_SCAN | 8'h08,
		// start line 0, no vertical offset
		oled_pkg::CTRL_CMD_SINGLE, oled_pkg::CMD_START_LINE,
		oled_pkg::CTRL_CMD_STREAM, oled_pkg::CMD_DISPLAY_OFFS, 8'h00,
		// full contrast
		oled_pkg::CTRL_CMD_STREAM, oled_pkg::CMD_CONTRAST, 8'hff,
		// not inverted
		oled_pkg::CTRL_CMD_SINGLE, oled_pkg::CMD_NORMAL,
		// charge pump on
		oled_pkg::CTRL_CMD_STREAM, oled_pkg::CMD_CHARGE_PUMP, 8'h14,
		// panel on, show ram
		oled_pkg::CTRL_CMD_SINGLE, oled_pkg::CMD_DISPLAY_ON,
		oled_pkg::CTRL_CMD_SINGLE, oled_pkg::CMD_RESUME_RAM
	};

	// column and page window over the whole panel
	localparam oled_pkg::bus_byte_t [0:oled_pkg::WINDOW_BYTES-1] WINDOW_TABLE = {
		oled_pkg::CTRL_CMD_STREAM, oled_pkg::CMD_COL_ADDR, 8'h00, 8'(SCREEN_WIDTH - 1),
		oled_pkg::CTRL_CMD_STREAM, oled_pkg::CMD_PAGE_ADDR, 8'h00, 8'(PAGES - 1)
	};

	// ------------------------------------------------------------------
	// state and counters
	// ------------------------------------------------------------------
	localparam int WAIT_MAX = (WAIT_RESET > WAIT_UPDATE) ? WAIT_RESET : WAIT_UPDATE;
	localparam int WAIT_BITS = $clog2(WAIT_MAX + 1);

	typedef enum logic [3:0] {
		ST_RESET_WAIT,
		ST_INIT_WRITE,
		ST_INIT_NEXT,
		ST_UPDATE_WAIT,
		ST_UPDATE_ARM,
		ST_WIN_WRITE,
		ST_WIN_NEXT,
		ST_DATA_CMD,
		ST_PIX_WRITE,
		ST_PIX_NEXT
	} state_t;

	state_t state, state_next;
	logic [INIT_IDX_BITS-1:0] init_idx, init_idx_next;
	logic [WIN_IDX_BITS-1:0] win_idx, win_idx_next;
	logic [COL_BITS-1:0] col, col_next;
	logic [PAGE_BITS-1:0] page, page_next;
	logic [WAIT_BITS-1:0] wait_ctr;
	logic update_pending;

	// read address runs with the next counters, so rd_data matches col/page
	assign rd_col = col_next;
	assign rd_page = page_next;

	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			state <= ST_RESET_WAIT;
			init_idx <= '0;
			win_idx <= '0;
			col <= '0;
			page <= '0;
			wait_ctr <= '0;
			update_pending <= 1'b0;
		end else begin
			state <= state_next;
			init_idx <= init_idx_next;
			win_idx <= win_idx_next;
			col <= col_next;
			page <= page_next;
			// counts only inside the two wait states
			if (state == ST_RESET_WAIT || state == ST_UPDATE_WAIT) begin
				wait_ctr <= wait_ctr + 1'b1;
			end else begin
				wait_ctr <= '0;
			end
			// strobe is kept until the armed state consumes it
			if (state == ST_UPDATE_ARM) begin
				update_pending <= 1'b0;
			end else if (update) begin
				update_pending <= 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------
	// next state and bus outputs
	// ------------------------------------------------------------------
	always_comb begin
		state_next = state;
		init_idx_next = init_idx;
		win_idx_next = win_idx;
		col_next = col;
		page_next = page;
		bus.enable = 1'b0;
		bus.data = oled_pkg::CTRL_CMD_STREAM;

		unique case (state)
			// settle after reset
			ST_RESET_WAIT: begin
				if (wait_ctr == WAIT_BITS'(WAIT_RESET - 1)) begin
					state_next = ST_INIT_WRITE;
				end
			end

			// init sequence
			ST_INIT_WRITE: begin
				bus.enable = 1'b1;
				bus.data = INIT_TABLE[init_idx];
				if (bus.next_word) begin
					state_next = ST_INIT_NEXT;
				end
			end
			ST_INIT_NEXT: begin
				if (init_idx == INIT_IDX_BITS'(oled_pkg::INIT_BYTES - 1)) begin
					// enable low, writer closes with stop
					if (bus.ready) begin
						init_idx_next = '0;
						state_next = ST_UPDATE_WAIT;
					end
				end else begin
					init_idx_next = init_idx + 1'b1;
					state_next = ST_INIT_WRITE;
				end
			end

			// frame rate timer, then update strobe
			ST_UPDATE_WAIT: begin
				if (wait_ctr == WAIT_BITS'(WAIT_UPDATE - 1)) begin
					state_next = ST_UPDATE_ARM;
				end
			end
			ST_UPDATE_ARM: begin
				if (update_pending || update) begin
					state_next = ST_WIN_WRITE;
				end
			end

			// address window
			ST_WIN_WRITE: begin
				bus.enable = 1'b1;
				bus.data = WINDOW_TABLE[win_idx];
				if (bus.next_word) begin
					state_next = ST_WIN_NEXT;
				end
			end
			ST_WIN_NEXT: begin
				if (win_idx == WIN_IDX_BITS'(oled_pkg::WINDOW_BYTES - 1)) begin
					if (bus.ready) begin
						win_idx_next = '0;
						state_next = ST_DATA_CMD;
					end
				end else begin
					win_idx_next = win_idx + 1'b1;
					state_next = ST_WIN_WRITE;
				end
			end

			// data control byte opens the pixel transaction
			ST_DATA_CMD: begin
				bus.enable = 1'b1;
				bus.data = oled_pkg::CTRL_DATA_STREAM;
				if (bus.next_word) begin
					state_next = ST_PIX_WRITE;
				end
			end

			// pixel bytes straight from the buffer
			ST_PIX_WRITE: begin
				bus.enable = 1'b1;
				bus.data = rd_data;
				if (bus.next_word) begin
					state_next = ST_PIX_NEXT;
				end
			end
			ST_PIX_NEXT: begin
				if (col == COL_BITS'(SCREEN_WIDTH - 1)) begin
					if (page == PAGE_BITS'(PAGES - 1)) begin
						// last byte handed over, wait for stop
						if (bus.ready) begin
							col_next = '0;
							page_next = '0;
							state_next = ST_UPDATE_WAIT;
						end
					end else begin
						col_next = '0;
						page_next = page + 1'b1;
						state_next = ST_PIX_WRITE;
					end
				end else begin
					col_next = col + 1'b1;
					state_next = ST_PIX_WRITE;
				end
			end

			default: begin
				state_next = ST_RESET_WAIT;
			end
		endcase
	end

endmodule

//--- logic/i2c_byte_writer.sv
/*
 * write-only i2c master
 * opens a transfer with start and the panel address, sends one
 * byte per offered word, closes with stop when enable drops
 * ack bit is clocked but not evaluated
 */

`timescale 1ns/1ps

module i2c_byte_writer #(
	parameter int CLK_DIV = 32,
	localparam int DIV_BITS = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1
) (
	input  logic in_clk,
	input  logic in_rst,
	serial_bus_if.phy bus,
	output logic scl,
	output logic sda
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_START,
		ST_BYTE,
		ST_STOP
	} state_t;

	state_t state;
	logic [DIV_BITS-1:0] div_ctr;
	logic tick;
	logic [1:0] quarter;
	logic cell_end;
	// 0..7 data bits msb first, 8 is the ack slot
	logic [3:0] bit_cnt;
	oled_pkg::bus_byte_t shift;
	logic scl_next;
	logic sda_next;

	// ------------------------------------------------------------------
	// quarter-period divider
	// ------------------------------------------------------------------
	assign tick = (div_ctr == DIV_BITS'(CLK_DIV - 1));
	assign cell_end = tick && (quarter == 2'd3);

	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			div_ctr <= '0;
		end else if (tick) begin
			div_ctr <= '0;
		end else begin
			div_ctr <= div_ctr + 1'b1;
		end
	end

	// ------------------------------------------------------------------
	// bit sequencer
	// ------------------------------------------------------------------
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			state <= ST_IDLE;
			quarter <= 2'd0;
			bit_cnt <= 4'd0;
			bus.next_word <= 1'b0;
		end else begin
			bus.next_word <= 1'b0;
			if (tick) begin
				// quarter stays at 0 while idle
				if (state != ST_IDLE) begin
					quarter <= quarter + 1'b1;
				end
				unique case (state)
					ST_IDLE: begin
						if (bus.enable) begin
							state <= ST_START;
						end
					end
					ST_START: begin
						if (quarter == 2'd3) begin
							bit_cnt <= 4'd0;
							state <= ST_BYTE;
						end
					end
					ST_BYTE: begin
						if (quarter == 2'd3) begin
							if (bit_cnt != 4'd8) begin
								bit_cnt <= bit_cnt + 1'b1;
							end else if (bus.enable) begin
								// byte boundary, take the next word
								bit_cnt <= 4'd0;
								bus.next_word <= 1'b1;
							end else begin
								state <= ST_STOP;
							end
						end
					end
					ST_STOP: begin
						if (quarter == 2'd3) begin
							state <= ST_IDLE;
						end
					end
					default: begin
						state <= ST_IDLE;
					end
				endcase
			end
		end
	end

	// shift register, address after start, data at each boundary
	always_ff @(posedge in_clk) begin
		if (cell_end) begin
			if (state == ST_START) begin
				shift <= {oled_pkg::OLED_I2C_ADDR, 1'b0};
			end else if (state == ST_BYTE) begin
				if (bit_cnt == 4'd8) begin
					shift <= bus.data;
				end else begin
					shift <= {shift[6:0], 1'b0};
				end
			end
		end
	end

	assign bus.ready = (state == ST_IDLE);

	// ------------------------------------------------------------------
	// line levels per quarter
	// ------------------------------------------------------------------
	always_comb begin
		scl_next = 1'b1;
		sda_next = 1'b1;
		unique case (state)
			ST_IDLE: begin
				scl_next = 1'b1;
				sda_next = 1'b1;
			end
			// sda falls in q1 with scl high
			ST_START: begin
				scl_next = (quarter != 2'd3);
				sda_next = (quarter == 2'd0);
			end
			// scl high in q1 and q2, sda set in q0
			ST_BYTE: begin
				scl_next = quarter[0] ^ quarter[1];
				sda_next = (bit_cnt == 4'd8) ? 1'b1 : shift[7];
			end
			// sda rises in q2 with scl high
			ST_STOP: begin
				scl_next = (quarter != 2'd0);
				sda_next = quarter[1];
			end
			default: begin
				scl_next = 1'b1;
				sda_next = 1'b1;
			end
		endcase
	end

	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			scl <= 1'b1;
			sda <= 1'b1;
		end else begin
			scl <= scl_next;
			sda <= sda_next;
		end
	end

endmodule

//--- logic/oled_display.sv
/*
 * oled display subsystem top level
 * frame buffer, ssd1306 controller and i2c byte writer
 */

`timescale 1ns/1ps

module oled_display #(
	parameter int SCREEN_WIDTH = 128,
	parameter int SCREEN_HEIGHT = 64,
	// 20 ms and 50 ms at 50 MHz
	parameter int WAIT_RESET = 1_000_000,
	parameter int WAIT_UPDATE = 2_500_000,
	// about 400 kHz scl at 50 MHz
	parameter int CLK_DIV = 32,
	localparam int PAGES = SCREEN_HEIGHT / 8,
	localparam int COL_BITS = (SCREEN_WIDTH > 1) ? $clog2(SCREEN_WIDTH) : 1,
	localparam int PAGE_BITS = (PAGES > 1) ? $clog2(PAGES) : 1
) (
	input  logic in_clk,
	input  logic in_rst,
	input  logic update,

	// host write port
	input  logic fb_wr,
	input  logic [COL_BITS-1:0] fb_col,
	input  logic [PAGE_BITS-1:0] fb_page,
	input  oled_pkg::bus_byte_t fb_data,

	// i2c lines, 1 is released
	output logic scl,
	output logic sda
);

	logic [COL_BITS-1:0] rd_col;
	logic [PAGE_BITS-1:0] rd_page;
	oled_pkg::bus_byte_t rd_data;

	serial_bus_if u_bus ();

	frame_buffer #(
		.SCREEN_WIDTH (SCREEN_WIDTH),
		.SCREEN_HEIGHT(SCREEN_HEIGHT)
	) u_frame_buffer (
		.in_clk (in_clk),
		.wr     (fb_wr),
		.wr_col (fb_col),
		.wr_page(fb_page),
		.wr_data(fb_data),
		.rd_col (rd_col),
		.rd_page(rd_page),
		.rd_data(rd_data)
	);

	oled_serial #(
		.SCREEN_WIDTH (SCREEN_WIDTH),
		.SCREEN_HEIGHT(SCREEN_HEIGHT),
		.WAIT_RESET   (WAIT_RESET),
		.WAIT_UPDATE  (WAIT_UPDATE)
	) u_oled_serial (
		.in_clk (in_clk),
		.in_rst (in_rst),
		.update (update),
		.rd_col (rd_col),
		.rd_page(rd_page),
		.rd_data(rd_data),
		.bus    (u_bus.ctrl)
	);

	i2c_byte_writer #(
		.CLK_DIV(CLK_DIV)
	) u_i2c_byte_writer (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.bus   (u_bus.phy),
		.scl   (scl),
		.sda   (sda)
	);

endmodule

//--- sim/tb_clock_gen.sv
/*
 * testbench clock and reset source
 * free-running clock, reset held high for the first cycles
 */

`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 40,
	parameter int RESET_CYCLES = 4
) (
	output logic in_clk,
	output logic in_rst
);

	initial begin
		in_clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2) in_clk = ~in_clk;
		end
	end

	// released on a rising edge after the reset cycles
	initial begin
		in_rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge in_clk);
		in_rst <= 1'b0;
	end

endmodule

//--- sim/oled_display_chk.sv
/*
 * i2c writer checker
 * concurrent assertions on line levels and the byte handshake,
 * bound into every i2c_byte_writer instance
 */

`timescale 1ns/1ps

module oled_display_chk (
	input logic in_clk,
	input logic in_rst,
	input logic scl,
	input logic sda,
	input logic scl_next,
	input logic sda_next,
	input logic framing,
	input logic enable,
	input logic next_word,
	input logic ready
);

	// failed assertions so far
	int unsigned fail_cnt = 0;

	// sda moves with scl high only in start and stop
	sda_stable_a: assert property (@(posedge in_clk) disable iff (in_rst)
		(scl && scl_next && (sda_next != sda)) |-> framing)
	else begin
		$error("sda changed while scl was high outside start and stop");
		fail_cnt++;
	end

	// byte load only inside an open transfer, with a byte offered
	load_in_txn_a: assert property (@(posedge in_clk) disable iff (in_rst)
		next_word |-> (enable && !ready))
	else begin
		$error("next_word outside a transfer or without enable");
		fail_cnt++;
	end

	// one-cycle pulse
	load_pulse_a: assert property (@(posedge in_clk) disable iff (in_rst)
		next_word |=> !next_word)
	else begin
		$error("next_word held for more than one cycle");
		fail_cnt++;
	end

endmodule

bind i2c_byte_writer oled_display_chk u_writer_chk (
	.in_clk   (in_clk),
	.in_rst   (in_rst),
	.scl      (scl),
	.sda      (sda),
	.scl_next (scl_next),
	.sda_next (sda_next),
	.framing  ((state == ST_START) || (state == ST_STOP)),
	.enable   (bus.enable),
	.next_word(bus.next_word),
	.ready    (bus.ready)
);

//--- sim/tb_oled_display.sv
/*
 * oled display subsystem testbench
 * fills the frame buffer from an lfsr, decodes scl and sda into
 * i2c transactions and checks each one against a reference model
 */

`timescale 1ns/1ps

module tb_oled_display;

	// small panel, short waits
	localparam int SCREEN_WIDTH = 16;
	localparam int SCREEN_HEIGHT = 16;
	localparam int WAIT_RESET = 4;
	localparam int WAIT_UPDATE = 20;
	localparam int CLK_DIV = 2;
	localparam int CLK_PERIOD_NS = 40;
	localparam int PAGES = SCREEN_HEIGHT / 8;
	localparam int FB_BYTES = SCREEN_WIDTH * PAGES;
	localparam int COL_BITS = (SCREEN_WIDTH > 1) ? $clog2(SCREEN_WIDTH) : 1;
	localparam int PAGE_BITS = (PAGES > 1) ? $clog2(PAGES) : 1;

	// transaction kinds in sending order
	localparam int KIND_INIT = 0;
	localparam int KIND_WINDOW = 1;
	localparam int KIND_FRAME = 2;

	// all bytes of the run, address bytes included, 36 quarters each
	localparam int TEST_BYTES = (oled_pkg::INIT_BYTES + 1)
		+ 2 * (oled_pkg::WINDOW_BYTES + 1) + 2 * (FB_BYTES + 2);
	localparam longint WATCHDOG_NS = 2 * (longint'(TEST_BYTES) * 36 * CLK_DIV * CLK_PERIOD_NS
		+ longint'(WAIT_RESET + 8 * WAIT_UPDATE + 500) * CLK_PERIOD_NS);

	// ssd1306 power-up sequence, multiplex ratio follows the height
	localparam oled_pkg::bus_byte_t [0:oled_pkg::INIT_BYTES-1] INIT_SEQ = {
		8'h80, 8'ha5, 8'h80, 8'hae, 8'h00, 8'hd5, 8'hf0, 8'h00, 8'hd9, 8'h22,
		8'h00, 8'ha8, 8'(SCREEN_HEIGHT - 1), 8'h00, 8'h20, 8'h00, 8'h80, 8'ha1,
		8'h80, 8'hc8, 8'h80, 8'h40, 8'h00, 8'hd3, 8'h00, 8'h00, 8'h81, 8'hff,
		8'h80, 8'ha6, 8'h00, 8'h8d, 8'h14, 8'h80, 8'haf, 8'h80, 8'ha4
	};

	logic in_clk;
	logic in_rst;
	logic update;
	logic fb_wr;
	logic [COL_BITS-1:0] fb_col;
	logic [PAGE_BITS-1:0] fb_page;
	oled_pkg::bus_byte_t fb_data;
	logic scl;
	logic sda;

	// frame copy, page-major
	oled_pkg::bus_byte_t fb_model [FB_BYTES];
	logic [31:0] lfsr_state = 32'hd2de_1663;
	int err_cnt = 0;

	// decoder state, bytes and per-transaction lengths
	logic prev_scl;
	logic prev_sda;
	logic in_txn;
	logic bit_pending;
	logic bit_val;
	logic [8:0] rx_shift;
	int rx_bit_cnt;
	int cur_len;
	oled_pkg::bus_byte_t rx_bytes [$];
	int rx_lens [$];
	int start_cnt = 0;
	int txn_done = 0;

	tb_clock_gen #(
		.PERIOD_NS   (CLK_PERIOD_NS),
		.RESET_CYCLES(4)
	) u_clock_gen (
		.in_clk(in_clk),
		.in_rst(in_rst)
	);

	oled_display #(
		.SCREEN_WIDTH (SCREEN_WIDTH),
		.SCREEN_HEIGHT(SCREEN_HEIGHT),
		.WAIT_RESET   (WAIT_RESET),
		.WAIT_UPDATE  (WAIT_UPDATE),
		.CLK_DIV      (CLK_DIV)
	) u_oled_display (
		.in_clk (in_clk),
		.in_rst (in_rst),
		.update (update),
		.fb_wr  (fb_wr),
		.fb_col (fb_col),
		.fb_page(fb_page),
		.fb_data(fb_data),
		.scl    (scl),
		.sda    (sda)
	);

	// ------------------------------------------------------------------
	// random source and reference model
	// ------------------------------------------------------------------
	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic int expected_length(input int kind);
		if (kind == KIND_INIT) begin
			return oled_pkg::INIT_BYTES + 1;
		end else if (kind == KIND_WINDOW) begin
			return oled_pkg::WINDOW_BYTES + 1;
		end
		return FB_BYTES + 2;
	endfunction

	// byte idx of a transaction, address byte at 0
	function automatic oled_pkg::bus_byte_t expected_byte(input int kind, input int idx);
		oled_pkg::bus_byte_t b;
		if (idx == 0) begin
			b = {oled_pkg::OLED_I2C_ADDR, 1'b0};
		end else if (kind == KIND_INIT) begin
			b = INIT_SEQ[idx - 1];
		end else if (kind == KIND_WINDOW) begin
			// full column range, then full page range
			case (idx)
				1, 5: b = oled_pkg::CTRL_CMD_STREAM;
				2: b = 8'h21;
				4: b = 8'(SCREEN_WIDTH - 1);
				6: b = 8'h22;
				8: b = 8'(PAGES - 1);
				default: b = 8'h00;
			endcase
		end else if (idx == 1) begin
			b = oled_pkg::CTRL_DATA_STREAM;
		end else begin
			b = fb_model[idx - 2];
		end
		return b;
	endfunction

	// ------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------
	task automatic stop_on_error(input string line);
		err_cnt++;
		$display("%s", line);
		$display("Test failures found");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_byte(input string name, input oled_pkg::bus_byte_t got,
		input oled_pkg::bus_byte_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Error at %0t ns: %s is 0x%02h, expected 0x%02h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			stop_on_error($sformatf("Error at %0t ns: %s is %0d, expected %0d",
				$time, name, got, exp));
		end
	endtask

	// checker assertions
	always @(posedge in_clk) begin
		if (u_oled_display.u_i2c_byte_writer.u_writer_chk.fail_cnt != 0) begin
			stop_on_error("An assertion on the I2C writer failed");
		end
	end

	initial begin
		#(WATCHDOG_NS);
		stop_on_error("Timeout: the expected I2C transactions did not all arrive");
	end

	// ------------------------------------------------------------------
	// i2c decoder, sampled mid-cycle
	// ------------------------------------------------------------------
	always @(negedge in_clk) begin
		if (in_rst) begin
			prev_scl = 1'b1;
			prev_sda = 1'b1;
			in_txn = 1'b0;
			bit_pending = 1'b0;
		end else begin
			if (prev_scl && scl && prev_sda && !sda) begin
				// start opens a byte list
				start_cnt++;
				in_txn = 1'b1;
				bit_pending = 1'b0;
				rx_bit_cnt = 0;
				cur_len = 0;
			end else if (prev_scl && scl && !prev_sda && sda) begin
				if (!in_txn || rx_bit_cnt != 0) begin
					stop_on_error("STOP seen outside a transaction or inside a byte");
				end else begin
					rx_lens.push_back(cur_len);
					in_txn = 1'b0;
					bit_pending = 1'b0;
				end
			end else if (!prev_scl && scl) begin
				// bit kept until scl falls, a stop rise drops it
				bit_val = sda;
				bit_pending = in_txn;
			end else if (prev_scl && !scl && bit_pending) begin
				rx_shift = {rx_shift[7:0], bit_val};
				bit_pending = 1'b0;
				rx_bit_cnt++;
				// ack slot ignored
				if (rx_bit_cnt == 9) begin
					rx_bytes.push_back(rx_shift[8:1]);
					cur_len++;
					rx_bit_cnt = 0;
				end
			end
			prev_scl = scl;
			prev_sda = sda;
		end
	end

	// ------------------------------------------------------------------
	// compare, one decoded transaction at a time
	// ------------------------------------------------------------------
	initial begin : compare_txns
		int len;
		int kind;
		oled_pkg::bus_byte_t got;
		forever begin
			@(posedge in_clk);
			if (rx_lens.size() != 0) begin
				len = rx_lens.pop_front();
				// init first, then window and frame in turn
				if (txn_done == 0) begin
					kind = KIND_INIT;
				end else if (txn_done % 2 == 1) begin
					kind = KIND_WINDOW;
				end else begin
					kind = KIND_FRAME;
				end
				check_count($sformatf("length of transaction %0d", txn_done),
					len, expected_length(kind));
				for (int i = 0; i < len; i++) begin
					got = rx_bytes.pop_front();
					check_byte($sformatf("sda byte %0d of transaction %0d", i, txn_done),
						got, expected_byte(kind, i));
				end
				txn_done++;
			end
		end
	end

	// ------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------
	task automatic host_write(input int idx, input oled_pkg::bus_byte_t value);
		@(posedge in_clk);
		fb_wr <= 1'b1;
		fb_col <= COL_BITS'(idx % SCREEN_WIDTH);
		fb_page <= PAGE_BITS'(idx / SCREEN_WIDTH);
		fb_data <= value;
		fb_model[idx] = value;
	endtask

	task automatic host_release();
		@(posedge in_clk);
		fb_wr <= 1'b0;
	endtask

	task automatic pulse_update();
		@(posedge in_clk);
		update <= 1'b1;
		@(posedge in_clk);
		update <= 1'b0;
	endtask

	task automatic wait_txns(input int n);
		while (txn_done < n) begin
			@(posedge in_clk);
		end
	endtask

	// no new start within two update waits
	task automatic expect_quiet(input int starts);
		repeat (2 * WAIT_UPDATE) @(posedge in_clk);
		check_count("start count without update", start_cnt, starts);
	endtask

	initial begin : stimulus
		logic [31:0] bits;
		int idx;
		update <= 1'b0;
		fb_wr <= 1'b0;
		fb_col <= '0;
		fb_page <= '0;
		fb_data <= '0;
		@(negedge in_rst);
		// random frame
		for (int i = 0; i < FB_BYTES; i++) begin
			bits = take_bits(8);
			host_write(i, bits[7:0]);
		end
		host_release();
		// init, then idle until strobed
		wait_txns(1);
		expect_quiet(1);
		// window and first frame
		pulse_update();
		wait_txns(3);
		// rewrite a few bytes, strobe while the update timer runs
		for (int n = 0; n < 6; n++) begin
			idx = int'(take_bits(16)) % FB_BYTES;
			bits = take_bits(8);
			host_write(idx, bits[7:0]);
		end
		host_release();
		pulse_update();
		wait_txns(5);
		expect_quiet(5);
		if (err_cnt == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- vlog.f
logic/oled_pkg.sv
logic/serial_bus_if.sv
logic/frame_buffer.sv
logic/oled_serial.sv
logic/i2c_byte_writer.sv
logic/oled_display.sv
sim/tb_clock_gen.sv
sim/oled_display_chk.sv
sim/tb_oled_display.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the oled display testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_oled_display -f vlog.f \
	-Mdir obj_dir -o sim_oled_display > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_oled_display +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

grep -q "Test failures found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
